// File: fog_loop_top.f
src/fog_loop_pkg.sv
src/half_period_timer.sv
src/mod_phase_fsm.sv
src/err_demod.sv
src/fb_step_integrator.sv
src/phase_ramp_accum.sv
src/fog_loop_top.sv
bench/fog_loop_tb.sv

// File: Makefile
SIM := obj_dir/Vfog_loop_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): fog_loop_top.f $(wildcard src/*.sv) bench/fog_loop_tb.sv
	verilator --binary --assert -Wno-fatal --top-module fog_loop_tb -f fog_loop_top.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// File: bench/fog_loop_tb.sv
`timescale 1ns/1ps

module fog_loop_tb
	import fog_loop_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int N_PHASES   = 4;
	// error pulses waited for in each phase
	localparam int PERIODS    = 6;

	// half length, wait, polarity, gain shift and feedback per phase
	localparam int FREQ [N_PHASES] = '{8, 12, 5, 2};
	localparam int WAITS[N_PHASES] = '{3, 5, 0, 1};
	localparam int POL  [N_PHASES] = '{0, 1, 1, 0};
	localparam int GAIN [N_PHASES] = '{4, 3, 0, 0};
	localparam int FB   [N_PHASES] = '{0, 1, 0, 1};

	logic                        CLOCK_DAC_1 = 1'b0;
	logic                        rst_n;
	logic signed [ADC_W_DEF-1:0] adc;
	loop_cfg_t                   cfg;
	logic [DAC_W_DEF-1:0]        dac;
	logic                        mod_high;
	logic                        err_valid;
	logic signed [ACC_W-1:0]     err;
	logic signed [ACC_W-1:0]     step;

	// adc levels for the high and low half
	int                          a_val;
	int                          b_val;

	// reset history covering the cycle after release
	logic                        rst_q = 1'b0;
	logic                        rst_qq = 1'b0;

	// level run tracking on o_mod_high
	logic                        last_high;
	int                          run_len;
	int                          level_edges;

	// error pulse spacing and step prediction
	int                          since_valid;
	logic                        valid_seen;
	logic                        step_due;
	logic signed [ACC_W-1:0]     exp_step;

	// step one cycle back
	logic signed [ACC_W-1:0]     step_q;

	// dac probe trailing the level by one cycle
	logic                        dac_high;
	int                          dac_idx;
	logic [DAC_W_DEF-1:0]        hi_word;
	int                          hi_count;

	fog_loop_top #(
		.ADC_W (ADC_W_DEF),
		.DAC_W (DAC_W_DEF)
	) u_fog_loop_top (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n     (rst_n),
		.i_adc       (adc),
		.i_cfg       (cfg),
		.o_dac       (dac),
		.o_mod_high  (mod_high),
		.o_err_valid (err_valid),
		.o_err       (err),
		.o_step      (step)
	);

	always #(CLK_PERIOD / 2) CLOCK_DAC_1 = ~CLOCK_DAC_1;

	task automatic stop_with_failure();
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// settled samples per half times the level difference
	function automatic logic signed [ACC_W-1:0] expected_error(
		input loop_cfg_t c,
		input int        a,
		input int        b
	);
		int e;
		e = (int'(c.freq_cnt) - int'(c.wait_cnt)) * (a - b);
		return c.polarity ? -e : e;
	endfunction

	// closed loop adds the shifted error and open loop takes the fixed step
	function automatic logic signed [ACC_W-1:0] next_step(
		input loop_cfg_t               c,
		input logic signed [ACC_W-1:0] prev,
		input logic signed [ACC_W-1:0] e
	);
		if (c.fb_on) begin
			return prev + (e >>> c.gain_sel);
		end else begin
			return c.const_step;
		end
	endfunction

	// all phases back to back plus reset and pipeline slack
	function automatic int run_budget_cycles();
		int total;
		int p;
		total = 50;
		for (p = 0; p < N_PHASES; p++) begin
			total += PERIODS * 2 * FREQ[p] + 10;
		end
		return total;
	endfunction

	// adc follows the modulation level
	always @(negedge CLOCK_DAC_1) begin
		adc <= mod_high ? a_val[ADC_W_DEF-1:0] : b_val[ADC_W_DEF-1:0];
	end

	always @(posedge CLOCK_DAC_1) begin
		rst_q  <= rst_n;
		rst_qq <= rst_q;
		step_q <= step;
		if (!rst_n) begin
			last_high   <= 1'b0;
			run_len     <= 0;
			level_edges <= 0;
			since_valid <= 0;
			valid_seen  <= 1'b0;
			step_due    <= 1'b0;
			exp_step    <= '0;
			dac_high    <= 1'b0;
			dac_idx     <= 0;
			hi_word     <= '0;
			hi_count    <= 0;
		end else begin
			last_high <= mod_high;
			if (mod_high != last_high) begin
				run_len     <= 1;
				level_edges <= level_edges + 1;
			end else begin
				run_len <= run_len + 1;
			end
			// position of the cycle just ended within its half
			dac_high <= mod_high;
			dac_idx  <= (mod_high != last_high) ? 0 : run_len;
			if (dac_high && dac_idx == int'(cfg.freq_cnt >> 1)) begin
				hi_word  <= dac;
				hi_count <= hi_count + 1;
			end
			if (err_valid) begin
				since_valid <= 1;
				valid_seen  <= 1'b1;
				step_due    <= 1'b1;
				exp_step    <= next_step(cfg, step, err);
			end else begin
				since_valid <= since_valid + 1;
				step_due    <= 1'b0;
			end
		end
	end

	a_reset_outputs: assert property (
		@(posedge CLOCK_DAC_1)
		(!rst_n || !rst_q || !rst_qq) |-> (dac == '0 && !err_valid && step == '0 && !mod_high)
	) else begin
		$display("CHECK FAILED reset o_dac=%h o_err_valid=%h o_step=%h o_mod_high=%h expected 0",
			$sampled(dac), $sampled(err_valid), $sampled(step), $sampled(mod_high));
		stop_with_failure();
	end

	a_half_length: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!rst_n)
		(mod_high != last_high && level_edges != 0) |-> (run_len == int'(cfg.freq_cnt))
	) else begin
		$display("CHECK FAILED o_mod_high run %h expected %h", $sampled(run_len), cfg.freq_cnt);
		stop_with_failure();
	end

	a_err_spacing: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!rst_n)
		(err_valid && valid_seen) |-> (since_valid == 2 * int'(cfg.freq_cnt))
	) else begin
		$display("CHECK FAILED o_err_valid spacing %h expected %h",
			$sampled(since_valid), 2 * int'(cfg.freq_cnt));
		stop_with_failure();
	end

	a_err_value: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!rst_n)
		err_valid |-> (err == expected_error(cfg, a_val, b_val))
	) else begin
		$display("CHECK FAILED o_err got %h expected %h",
			$sampled(err), expected_error(cfg, a_val, b_val));
		stop_with_failure();
	end

	a_step_update: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!rst_n)
		step_due |-> (step == exp_step)
	) else begin
		$display("CHECK FAILED o_step got %h expected %h", $sampled(step), $sampled(exp_step));
		stop_with_failure();
	end

	// step only moves right after a pulse
	a_step_hold: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!rst_n)
		!step_due |-> $stable(step)
	) else begin
		$display("CHECK FAILED o_step got %h expected %h", $sampled(step), $sampled(step_q));
		stop_with_failure();
	end

	// ramp steps once per period; first add still sees the zero reset step
	a_dac_ramp: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!rst_n)
		(dac_high && dac_idx == int'(cfg.freq_cnt >> 1) && hi_count != 0 && !cfg.fb_on)
		|-> (16'(dac - hi_word) == ((hi_count >= 2) ? cfg.const_step[15:0] : 16'h0000))
	) else begin
		$display("CHECK FAILED o_dac got %h previous high %h step %h",
			$sampled(dac), $sampled(hi_word), cfg.const_step[15:0]);
		stop_with_failure();
	end

	// same ramp inside one period, so only the square wave differs
	a_dac_mod: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!rst_n)
		(!dac_high && dac_idx == int'(cfg.freq_cnt >> 1) && hi_count != 0)
		|-> (16'(hi_word - dac) == 16'(cfg.amp << 1))
	) else begin
		$display("CHECK FAILED o_dac low got %h high %h amp %h",
			$sampled(dac), $sampled(hi_word), cfg.amp);
		stop_with_failure();
	end

	task automatic apply_phase(input int p);
		@(negedge CLOCK_DAC_1);
		rst_n = 1'b0;
		cfg.freq_cnt   = 16'(FREQ[p]);
		cfg.wait_cnt   = 16'(WAITS[p]);
		cfg.amp        = 16'($urandom);
		cfg.polarity   = 1'(POL[p]);
		cfg.gain_sel   = 5'(GAIN[p]);
		cfg.fb_on      = 1'(FB[p]);
		cfg.const_step = $urandom;
		// levels within the signed adc range
		a_val = int'($urandom % 16384) - 8192;
		b_val = int'($urandom % 16384) - 8192;
		repeat (2) @(negedge CLOCK_DAC_1);
		rst_n = 1'b1;
	endtask

	initial begin
		int p;
		int pulses;
		void'($urandom(35534));
		rst_n = 1'b0;
		cfg   = '0;
		adc   = '0;
		a_val = 0;
		b_val = 0;
		for (p = 0; p < N_PHASES; p++) begin
			apply_phase(p);
			pulses = 0;
			while (pulses < PERIODS) begin
				@(posedge CLOCK_DAC_1);
				if (err_valid) begin
					pulses++;
				end
			end
			// step update follows the last pulse
			repeat (2) @(negedge CLOCK_DAC_1);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		#(run_budget_cycles() * CLK_PERIOD);
		$display("timeout: error pulses stopped before all phases finished");
		stop_with_failure();
	end

endmodule

// File: src/fog_loop_top.sv
`timescale 1ns/1ps

module fog_loop_top
	import fog_loop_pkg::*;
#(
	parameter int ADC_W = ADC_W_DEF,
	parameter int DAC_W = DAC_W_DEF
) (
	input  logic                    CLOCK_DAC_1,
	input  logic                    i_rst_n,
	input  logic signed [ADC_W-1:0] i_adc,
	input  loop_cfg_t               i_cfg,
	output logic [DAC_W-1:0]        o_dac,
	output logic                    o_mod_high,
	output logic                    o_err_valid,
	output logic signed [ACC_W-1:0] o_err,
	output logic signed [ACC_W-1:0] o_step
);

	// modulator markers shared by the data path
	mod_tick_t               tick;

	// demodulated error, valid-only pulse
	logic                    err_valid;
	logic signed [ACC_W-1:0] err;

	// feedback phase step
	logic signed [ACC_W-1:0] step;

	// square-wave sequencer
	mod_phase_fsm u_fsm (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n     (i_rst_n),
		.i_cfg       (i_cfg),
		.o_tick      (tick)
	);

	// high half minus low half, once per period
	err_demod #(
		.ADC_W (ADC_W)
	) u_demod (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n     (i_rst_n),
		.i_tick      (tick),
		.i_adc       (i_adc),
		.i_polarity  (i_cfg.polarity),
		.o_err_valid (err_valid),
		.o_err       (err)
	);

	// error to step
	fb_step_integrator u_integ (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n     (i_rst_n),
		.i_err_valid (err_valid),
		.i_err       (err),
		.i_cfg       (i_cfg),
		.o_step      (step)
	);

	// ramp plus modulation into the DAC
	phase_ramp_accum #(
		.DAC_W (DAC_W)
	) u_ramp (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n     (i_rst_n),
		.i_tick      (tick),
		.i_step      (step),
		.i_amp       (i_cfg.amp),
		.o_dac       (o_dac)
	);

	// observation taps
	assign o_mod_high  = tick.high;
	assign o_err_valid = err_valid;
	assign o_err       = err;
	assign o_step      = step;

endmodule

// File: src/phase_ramp_accum.sv
`timescale 1ns/1ps

module phase_ramp_accum
	import fog_loop_pkg::*;
#(
	parameter int DAC_W = DAC_W_DEF
) (
	input  logic                    CLOCK_DAC_1,
	input  logic                    i_rst_n,
	input  mod_tick_t               i_tick,
	input  logic signed [ACC_W-1:0] i_step,
	input  logic [AMP_W-1:0]        i_amp,
	output logic [DAC_W-1:0]        o_dac
);

	// phase ramp, wraps modulo 2^DAC_W
	logic [DAC_W-1:0] ramp;

	// amplitude resized to the DAC word
	logic [DAC_W-1:0] amp_w;

	// set once the first high half has been seen
	logic             run;

	// word for the next DAC cycle
	logic [DAC_W-1:0] dac_nxt;

	assign amp_w = DAC_W'(i_amp);

	// square wave on top of the ramp
	// before the first high half the DAC sits at the bare ramp
	always_comb begin
		if (i_tick.high) begin
			dac_nxt = ramp + amp_w;
		end else if (run) begin
			dac_nxt = ramp - amp_w;
		end else begin
			dac_nxt = ramp;
		end
	end

	always_ff @(posedge CLOCK_DAC_1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ramp  <= '0;
			run   <= 1'b0;
			o_dac <= '0;
		end else begin
			// one step per period, low bits only
			if (i_tick.period_end) begin
				ramp <= ramp + i_step[DAC_W-1:0];
			end
			if (i_tick.high) begin
				run <= 1'b1;
			end
			o_dac <= dac_nxt;
		end
	end

endmodule

// File: src/fb_step_integrator.sv
`timescale 1ns/1ps

module fb_step_integrator
	import fog_loop_pkg::*;
(
	input  logic                    CLOCK_DAC_1,
	input  logic                    i_rst_n,
	input  logic                    i_err_valid,
	input  logic signed [ACC_W-1:0] i_err,
	input  loop_cfg_t               i_cfg,
	output logic signed [ACC_W-1:0] o_step
);

	// loop gain as a power-of-two divide
	logic signed [ACC_W-1:0] err_scaled;

	// integrated step for the next value
	logic signed [ACC_W-1:0] step_nxt;

	// sign kept by the arithmetic shift
	assign err_scaled = i_err >>> i_cfg.gain_sel;

	// closed loop integrates, open loop forces the fixed step
	always_comb begin
		if (i_cfg.fb_on) begin
			step_nxt = o_step + err_scaled;
		end else begin
			step_nxt = i_cfg.const_step;
		end
	end

	// step moves only on an error pulse
	always_ff @(posedge CLOCK_DAC_1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_step <= '0;
		end else if (i_err_valid) begin
			o_step <= step_nxt;
		end
	end

endmodule

// File: src/err_demod.sv
`timescale 1ns/1ps

module err_demod
	import fog_loop_pkg::*;
#(
	parameter int ADC_W = ADC_W_DEF
) (
	input  logic                    CLOCK_DAC_1,
	input  logic                    i_rst_n,
	input  mod_tick_t               i_tick,
	input  logic signed [ADC_W-1:0] i_adc,
	input  logic                    i_polarity,
	output logic                    o_err_valid,
	output logic signed [ACC_W-1:0] o_err
);

	// sample widened to the sum width
	logic signed [ACC_W-1:0] adc_ext;

	// running sums per half
	logic signed [ACC_W-1:0] sum_high;
	logic signed [ACC_W-1:0] sum_low;

	// sums including this cycle's sample
	logic signed [ACC_W-1:0] high_nxt;
	logic signed [ACC_W-1:0] low_nxt;

	// high minus low over the full period
	logic signed [ACC_W-1:0] diff;

	// which sum takes the sample
	logic                    take_high;
	logic                    take_low;

	assign adc_ext = {{(ACC_W-ADC_W){i_adc[ADC_W-1]}}, i_adc};

	assign take_high = i_tick.settled && i_tick.high;
	assign take_low  = i_tick.settled && !i_tick.high;

	// period_end is also settled, so the last low sample lands here
	assign high_nxt = take_high ? sum_high + adc_ext : sum_high;
	assign low_nxt  = take_low  ? sum_low  + adc_ext : sum_low;

	assign diff = high_nxt - low_nxt;

	always_ff @(posedge CLOCK_DAC_1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sum_high    <= '0;
			sum_low     <= '0;
			o_err_valid <= 1'b0;
			o_err       <= '0;
		end else begin
			// one pulse per period, no back-pressure
			o_err_valid <= i_tick.period_end;
			if (i_tick.period_end) begin
				// report and restart both sums
				o_err    <= i_polarity ? -diff : diff;
				sum_high <= '0;
				sum_low  <= '0;
			end else begin
				sum_high <= high_nxt;
				sum_low  <= low_nxt;
			end
		end
	end

	// a period is at least four cycles long
	a_err_single_pulse: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!i_rst_n)
		o_err_valid |=> !o_err_valid
	);

endmodule

// File: src/mod_phase_fsm.sv
`timescale 1ns/1ps

module mod_phase_fsm
	import fog_loop_pkg::*;
(
	input  logic       CLOCK_DAC_1,
	input  logic       i_rst_n,
	input  loop_cfg_t  i_cfg,
	output mod_tick_t  o_tick
);

	mod_state_e state;
	mod_state_e state_nxt;

	// timer handshake
	logic      load;
	logic      expired;
	logic      settled;

	// any half in progress
	logic      in_half;
	mod_tick_t tick_nxt;

	half_period_timer u_timer (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n     (i_rst_n),
		.i_load      (load),
		.i_freq_cnt  (i_cfg.freq_cnt),
		.i_wait_cnt  (i_cfg.wait_cnt),
		.o_expired   (expired),
		.o_settled   (settled)
	);

	assign in_half = (state != IDLE);

	// reload on leaving idle and at the end of every half
	assign load = (state == IDLE) || expired;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:      state_nxt = HALF_HIGH;
			HALF_HIGH: if (expired) state_nxt = HALF_LOW;
			HALF_LOW:  if (expired) state_nxt = HALF_HIGH;
			default:   state_nxt = IDLE;
		endcase
	end

	// markers valid only inside a half
	always_comb begin
		tick_nxt.high       = (state == HALF_HIGH);
		tick_nxt.settled    = in_half && settled;
		tick_nxt.half_last  = in_half && expired;
		tick_nxt.period_end = (state == HALF_LOW) && expired;
	end

	// tick trails the state by one cycle
	always_ff @(posedge CLOCK_DAC_1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state  <= IDLE;
			o_tick <= '0;
		end else begin
			state  <= state_nxt;
			o_tick <= tick_nxt;
		end
	end

	// period closes on the last low cycle and a high half follows
	a_period_end_low: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!i_rst_n)
		o_tick.period_end |-> (o_tick.half_last && !o_tick.high) ##1 o_tick.high
	);

	// level flips right after every half boundary
	a_half_toggle: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!i_rst_n)
		o_tick.half_last |=> (o_tick.high != $past(o_tick.high))
	);

endmodule

// File: src/half_period_timer.sv
`timescale 1ns/1ps

module half_period_timer
	import fog_loop_pkg::*;
(
	input  logic             CLOCK_DAC_1,
	input  logic             i_rst_n,
	input  logic             i_load,
	input  logic [CNT_W-1:0] i_freq_cnt,
	input  logic [CNT_W-1:0] i_wait_cnt,
	output logic             o_expired,
	output logic             o_settled
);

	// cycles left in the current half
	logic [CNT_W-1:0] cnt;
	// cycles already spent in the current half
	logic [CNT_W-1:0] elapsed;

	// reload at half start, then count down and park at zero
	always_ff @(posedge CLOCK_DAC_1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= '0;
		end else if (i_load) begin
			cnt <= i_freq_cnt - 1'b1;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// first cycle of a half has elapsed == 0
	assign elapsed = i_freq_cnt - 1'b1 - cnt;

	// zero marks the last cycle of the half
	assign o_expired = (cnt == '0);

	// window covers the last freq_cnt - wait_cnt cycles
	assign o_settled = (elapsed >= i_wait_cnt);

	// a wait as long as the half would leave no samples at all
	a_wait_below_freq: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!i_rst_n)
		i_load |-> (i_wait_cnt < i_freq_cnt)
	);

endmodule

// File: src/fog_loop_pkg.sv
package fog_loop_pkg;

	// default converter widths, overridable at the top level
	parameter int ADC_W_DEF = 14;
	parameter int DAC_W_DEF = 16;

	// width of error sums, step and other loop words
	parameter int ACC_W = 32;

	// half-period and wait counters
	parameter int CNT_W = 16;

	// modulation amplitude
	parameter int AMP_W = 16;

	// error shift select
	parameter int GAIN_W = 5;

	// run settings, held stable while the loop runs
	typedef struct packed {
		// cycles per half-period, at least 2
		logic [CNT_W-1:0]        freq_cnt;
		// cycles skipped at the start of a half, below freq_cnt
		logic [CNT_W-1:0]        wait_cnt;
		// square-wave amplitude in DAC counts
		logic [AMP_W-1:0]        amp;
		// flips the sign of the error
		logic                    polarity;
		// arithmetic right shift applied to the error
		logic [GAIN_W-1:0]       gain_sel;
		// closed loop when set
		logic                    fb_on;
		// open-loop step
		logic signed [ACC_W-1:0] const_step;
	} loop_cfg_t;

	// modulator sequence
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		HALF_HIGH = 2'd1,
		HALF_LOW  = 2'd2
	} mod_state_e;

	// per-cycle markers from the modulator to the data path
	typedef struct packed {
		// current half is the high one
		logic high;
		// inside the sampling window
		logic settled;
		// last cycle of either half
		logic half_last;
		// last cycle of a low half, closes the period
		logic period_end;
	} mod_tick_t;

endpackage
